//--- logic/enigma_pkg.sv
package enigma_pkg;

	// symbol and table geometry
	localparam int SYM_W      = 6;
	localparam int TAB_DEPTH  = 64;
	localparam int N_ROTORS   = 3;
	localparam int LOAD_IDX_W = 8;

	typedef logic [SYM_W-1:0] sym_t;

	// also the top two bits of the load index
	typedef enum logic [1:0] {
		ROT_A    = 2'd0,
		ROT_B    = 2'd1,
		ROT_C    = 2'd2,
		ROT_NONE = 2'd3
	} rotor_sel_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		LOAD  = 2'd1,
		READY = 2'd2
	} mode_t;

	// one lookup per phase, then the output cycle
	typedef enum logic [2:0] {
		PH_FWD_A = 3'd0,
		PH_FWD_B = 3'd1,
		PH_FWD_C = 3'd2,
		PH_INV_C = 3'd3,
		PH_INV_B = 3'd4,
		PH_INV_A = 3'd5,
		PH_OUT   = 3'd6
	} phase_t;

	localparam sym_t RET_OFS_B = 6'd1;
	localparam sym_t RET_OFS_A = 6'd4;

	localparam int B_STEP_EVERY = 2;
	localparam int B_CNT_W      = $clog2(B_STEP_EVERY);

endpackage

//--- logic/rotor_if.sv
`timescale 1ns/1ps

// lookup port of the rotor bank, one lookup per cycle
interface rotor_if
	import enigma_pkg::*;
();

	rotor_sel_t sel;
	logic       inv;    // 0 forward, 1 inverse
	sym_t       key;
	sym_t       result; // same cycle
	logic       step;
	logic       step_b;

	modport ctrl (
		output sel,
		output inv,
		output key,
		output step,
		output step_b,
		input  result
	);

	modport bank (
		input  sel,
		input  inv,
		input  key,
		input  step,
		input  step_b,
		output result
	);

endinterface

//--- logic/rotor_bank.sv
`timescale 1ns/1ps

module rotor_bank
	import enigma_pkg::*;
(
	input  logic                  clk,
	input  logic                  srstn,
	input  logic                  load_en_i,
	input  logic                  ready_enter_i,
	input  logic [LOAD_IDX_W-1:0] load_idx_i,
	input  sym_t                  load_data_i,
	rotor_if.bank                 rif
);

	sym_t       rotor_tab [N_ROTORS][TAB_DEPTH];
	sym_t       ofs_a;
	sym_t       ofs_b;
	rotor_sel_t wr_sel;
	sym_t       wr_addr;
	sym_t       cur_tab [TAB_DEPTH];
	sym_t       cur_ofs;
	logic       cur_vld;
	sym_t       fwd_addr;
	sym_t       fwd_data;
	logic       inv_hit;
	sym_t       inv_pos;

	assign wr_sel  = rotor_sel_t'(load_idx_i[LOAD_IDX_W-1:SYM_W]);
	assign wr_addr = load_idx_i[SYM_W-1:0];

	// table writes, index 3 selects nothing
	always_ff @(posedge clk) begin
		if (load_en_i && (wr_sel != ROT_NONE)) begin
			rotor_tab[wr_sel][wr_addr] <= load_data_i;
		end
	end

	// rotation offsets, C stays put
	always_ff @(posedge clk) begin
		if (!srstn || ready_enter_i) begin
			ofs_a <= '0;
			ofs_b <= '0;
		end else if (rif.step) begin
			ofs_a <= ofs_a + sym_t'(1);
			if (rif.step_b) begin
				ofs_b <= ofs_b + sym_t'(1);
			end
		end
	end

	// selected rotor and its offset
	always_comb begin
		cur_vld = 1'b1;
		cur_ofs = '0;
		case (rif.sel)
			ROT_A: cur_ofs = ofs_a;
			ROT_B: cur_ofs = ofs_b;
			ROT_C: cur_ofs = '0;
			default: cur_vld = 1'b0;
		endcase
	end

	always_comb begin
		for (int j = 0; j < TAB_DEPTH; j++) begin
			case (rif.sel)
				ROT_A: cur_tab[j] = rotor_tab[0][j];
				ROT_B: cur_tab[j] = rotor_tab[1][j];
				ROT_C: cur_tab[j] = rotor_tab[2][j];
				default: cur_tab[j] = '0;
			endcase
		end
	end

	// forward: rotated[key] is the stored entry at key - ofs
	assign fwd_addr = rif.key - cur_ofs;
	assign fwd_data = cur_tab[fwd_addr];

	// inverse: match search over all entries, lowest index wins
	always_comb begin
		inv_hit = 1'b0;
		inv_pos = '0;
		for (int j = TAB_DEPTH - 1; j >= 0; j--) begin
			if (cur_tab[j] == rif.key) begin
				inv_hit = 1'b1;
				inv_pos = sym_t'(j);
			end
		end
	end

	always_comb begin
		if (!cur_vld) begin
			rif.result = '0;
		end else if (rif.inv) begin
			rif.result = inv_hit ? (inv_pos + cur_ofs) : '0; // no match gives 0
		end else begin
			rif.result = fwd_data;
		end
	end

endmodule

//--- logic/enigma_ctrl.sv
`timescale 1ns/1ps

module enigma_ctrl
	import enigma_pkg::*;
(
	input  logic  clk,
	input  logic  srstn,
	input  logic  load_i,
	input  logic  encrypt_i,
	input  sym_t  code_in_i,
	output logic  load_en_o,
	output logic  ready_enter_o,
	rotor_if.ctrl rif,
	output sym_t  code_out_o,
	output logic  code_valid_o,
	output logic  ready_o
);

	mode_t              mode;
	mode_t              mode_nxt;
	phase_t             phase;
	logic               busy;
	logic               start;
	logic               out_cyc;
	sym_t               sym_q;
	sym_t               sym_nxt;
	logic [B_CNT_W-1:0] sym_cnt;
	logic               b_due;

	always_comb begin
		mode_nxt = mode;
		case (mode)
			IDLE: begin
				if (load_i) begin
					mode_nxt = LOAD;
				end
			end
			LOAD: begin
				if (!load_i) begin
					mode_nxt = READY;
				end
			end
			READY: mode_nxt = READY; // only reset leaves
			default: mode_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!srstn) begin
			mode <= IDLE;
		end else begin
			mode <= mode_nxt;
		end
	end

	assign load_en_o     = load_i && ((mode == IDLE) || (mode == LOAD));
	assign ready_enter_o = (mode == LOAD) && !load_i;

	assign start   = (mode == READY) && ready_o && encrypt_i;
	assign out_cyc = busy && (phase == PH_OUT);
	assign b_due   = (sym_cnt == B_CNT_W'(B_STEP_EVERY - 1));

	// lookup for the current phase
	always_comb begin
		rif.sel = ROT_NONE;
		rif.inv = 1'b0;
		if (busy) begin
			case (phase)
				PH_FWD_A: rif.sel = ROT_A;
				PH_FWD_B: rif.sel = ROT_B;
				PH_FWD_C: rif.sel = ROT_C;
				PH_INV_C: begin
					rif.sel = ROT_C;
					rif.inv = 1'b1;
				end
				PH_INV_B: begin
					rif.sel = ROT_B;
					rif.inv = 1'b1;
				end
				PH_INV_A: begin
					rif.sel = ROT_A;
					rif.inv = 1'b1;
				end
				default: rif.sel = ROT_NONE;
			endcase
		end
	end

	assign rif.key    = sym_q;
	assign rif.step   = out_cyc;          // offsets move as the symbol leaves
	assign rif.step_b = out_cyc && b_due; // every second symbol

	always_comb begin
		case (phase)
			PH_FWD_C: sym_nxt = sym_t'(TAB_DEPTH - 1) - rif.result; // reflector
			PH_INV_B: sym_nxt = rif.result - RET_OFS_B;
			PH_INV_A: sym_nxt = rif.result - RET_OFS_A;
			PH_OUT:   sym_nxt = sym_q;
			default:  sym_nxt = rif.result;
		endcase
	end

	// running symbol
	always_ff @(posedge clk) begin
		if (start) begin
			sym_q <= code_in_i;
		end else if (busy) begin
			sym_q <= sym_nxt;
		end
	end

	// phase sequencer
	always_ff @(posedge clk) begin
		if (!srstn) begin
			busy  <= 1'b0;
			phase <= PH_FWD_A;
		end else if (start) begin
			busy  <= 1'b1;
			phase <= PH_FWD_A;
		end else if (out_cyc) begin
			busy  <= 1'b0;
			phase <= PH_FWD_A;
		end else if (busy) begin
			phase <= phase_t'(phase + 3'd1);
		end
	end

	// symbol parity for rotor B
	always_ff @(posedge clk) begin
		if (!srstn || ready_enter_o) begin
			sym_cnt <= '0;
		end else if (out_cyc) begin
			sym_cnt <= b_due ? '0 : sym_cnt + 1'b1;
		end
	end

	// outputs and host handshake
	always_ff @(posedge clk) begin
		if (!srstn) begin
			ready_o      <= 1'b0;
			code_valid_o <= 1'b0;
			code_out_o   <= '0;
		end else begin
			code_valid_o <= out_cyc;
			if (out_cyc) begin
				code_out_o <= sym_q;
			end
			if (ready_enter_o || out_cyc) begin
				ready_o <= 1'b1;
			end else if (start) begin
				ready_o <= 1'b0;
			end
		end
	end

endmodule

//--- logic/enigma_top.sv
`timescale 1ns/1ps

module enigma_top
	import enigma_pkg::*;
(
	input  logic                  clk,
	input  logic                  srstn,
	input  logic                  load_i,
	input  logic                  encrypt_i,
	input  logic [LOAD_IDX_W-1:0] load_idx_i,
	input  sym_t                  code_in_i,
	output sym_t                  code_out_o,
	output logic                  code_valid_o,
	output logic                  ready_o
);

	logic load_en;
	logic ready_enter; // offsets restart here

	rotor_if rif ();

	// sequencing, reflector, output registers
	enigma_ctrl enigma_ctrl_i (
		.clk           (clk),
		.srstn         (srstn),
		.load_i        (load_i),
		.encrypt_i     (encrypt_i),
		.code_in_i     (code_in_i),
		.load_en_o     (load_en),
		.ready_enter_o (ready_enter),
		.rif           (rif),
		.code_out_o    (code_out_o),
		.code_valid_o  (code_valid_o),
		.ready_o       (ready_o)
	);

	// code_in doubles as load data
	rotor_bank rotor_bank_i (
		.clk           (clk),
		.srstn         (srstn),
		.load_en_i     (load_en),
		.ready_enter_i (ready_enter),
		.load_idx_i    (load_idx_i),
		.load_data_i   (code_in_i),
		.rif           (rif)
	);

endmodule

//--- dv/enigma_chk.sv
`timescale 1ns/1ps

module enigma_chk
	import enigma_pkg::*;
(
	input logic  clk,
	input logic  srstn,
	input mode_t mode_i,
	input logic  busy_i,
	input logic  ready_i,
	input logic  code_valid_i
);

	// output strobe is a single cycle
	a_valid_pulse: assert property (@(posedge clk) disable iff (!srstn)
		code_valid_i |=> !code_valid_i)
		else $error("code_valid_o stayed high for two cycles");

	// symbol in flight from capture until the strobe
	a_ready_low: assert property (@(posedge clk) disable iff (!srstn)
		busy_i |-> !ready_i)
		else $error("ready_o high while a symbol is in flight");

	a_valid_mode: assert property (@(posedge clk) disable iff (!srstn)
		$rose(code_valid_i) |-> (mode_i == READY))
		else $error("code_valid_o rose outside READY");

endmodule

bind enigma_ctrl enigma_chk enigma_chk_i (
	.clk          (clk),
	.srstn        (srstn),
	.mode_i       (mode),
	.busy_i       (busy),
	.ready_i      (ready_o),
	.code_valid_i (code_valid_o)
);

//--- dv/enigma_model.svh
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

// reference copy of the rotor tables and positions
sym_t rot_tab [3][TAB_DEPTH];
sym_t pos_a;
sym_t pos_b;
int   done_count; // symbols since READY

// entry at key minus the rotor position
function automatic sym_t fwd_lookup(input int r, input sym_t key, input sym_t k);
	sym_t addr;
	addr = key - k;
	return rot_tab[r][addr];
endfunction

// lowest matching index plus the rotor position, 0 when nothing matches
function automatic sym_t inv_lookup(input int r, input sym_t key, input sym_t k);
	for (int j = 0; j < TAB_DEPTH; j++) begin
		if (rot_tab[r][j] == key) begin
			return sym_t'(j) + k;
		end
	end
	return '0;
endfunction

function automatic sym_t expected_code(input sym_t x);
	sym_t a;
	sym_t b;
	sym_t c;
	sym_t refl;
	sym_t ib;
	a    = fwd_lookup(0, x, pos_a);
	b    = fwd_lookup(1, a, pos_b);
	c    = fwd_lookup(2, b, 6'd0);
	refl = 6'd63 - c;
	ib   = inv_lookup(1, inv_lookup(2, refl, 6'd0), pos_b) - RET_OFS_B;
	return inv_lookup(0, ib, pos_a) - RET_OFS_A;
endfunction

function automatic void advance_rotors();
	done_count++;
	pos_a = pos_a + 6'd1;
	if (done_count % B_STEP_EVERY == 0) begin
		pos_b = pos_b + 6'd1; // every second symbol
	end
endfunction

function automatic void restart_rotors();
	pos_a      = '0;
	pos_b      = '0;
	done_count = 0;
endfunction

`endif

//--- dv/enigma_tb.sv
`timescale 1ns/1ps

module enigma_tb
	import enigma_pkg::*;
();

	localparam int TIMEOUT = 40; // cycles per wait

	logic                  clk;
	logic                  srstn;
	logic                  load_i;
	logic                  encrypt_i;
	logic [LOAD_IDX_W-1:0] load_idx_i;
	sym_t                  code_in_i;
	sym_t                  code_out_o;
	logic                  code_valid_o;
	logic                  ready_o;
	integer                seed;

	`include "enigma_model.svh"

	enigma_top enigma_top_i (
		.clk          (clk),
		.srstn        (srstn),
		.load_i       (load_i),
		.encrypt_i    (encrypt_i),
		.load_idx_i   (load_idx_i),
		.code_in_i    (code_in_i),
		.code_out_o   (code_out_o),
		.code_valid_o (code_valid_o),
		.ready_o      (ready_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ready_o && n < TIMEOUT);
		if (!ready_o) begin
			stop_on_error("timeout waiting for ready_o");
		end
	endtask

	// called right after a rising edge, returns on the edge that writes
	task automatic write_entry(input logic [LOAD_IDX_W-1:0] idx, input sym_t data);
		load_i     <= 1'b1;
		load_idx_i <= idx;
		code_in_i  <= data;
		@(negedge clk);
		assert (!ready_o) else
			stop_on_error($sformatf("** Error: ready_o = %h during load, expected %h",
				ready_o, 1'b0));
		@(posedge clk);
	endtask

	task automatic load_tables();
		int   k;
		sym_t tmp;
		for (int r = 0; r < 3; r++) begin
			for (int j = 0; j < TAB_DEPTH; j++) begin
				rot_tab[r][j] = sym_t'(j);
			end
			for (int j = TAB_DEPTH - 1; j > 0; j--) begin
				k = $unsigned($random(seed)) % (j + 1);
				tmp           = rot_tab[r][j];
				rot_tab[r][j] = rot_tab[r][k];
				rot_tab[r][k] = tmp;
			end
		end
		@(posedge clk);
		for (int r = 0; r < 3; r++) begin
			for (int j = 0; j < TAB_DEPTH; j++) begin
				if (($random(seed) & 7) == 0) begin
					write_entry({2'b11, 6'($random(seed))}, sym_t'($random(seed))); // no rotor
				end
				write_entry({2'(r), 6'(j)}, rot_tab[r][j]);
			end
		end
		load_i <= 1'b0;
	endtask

	// writes attempted in READY must not reach the tables
	task automatic load_in_ready();
		for (int i = 0; i < 24; i++) begin
			@(posedge clk);
			load_i     <= 1'b1;
			load_idx_i <= LOAD_IDX_W'($random(seed));
			code_in_i  <= sym_t'($random(seed));
		end
		@(posedge clk);
		load_i <= 1'b0;
		@(negedge clk);
		assert (ready_o) else
			stop_on_error($sformatf("** Error: ready_o = %h after load in READY, expected %h",
				ready_o, 1'b1));
	endtask

	task automatic run_symbols(input int count, input bit hold);
		sym_t syms[$];
		sym_t exp_code;
		int   n;
		for (int i = 0; i < count; i++) begin
			syms.push_back(sym_t'($random(seed)));
		end
		for (int i = 0; i < count; i++) begin
			if (i == 0 || !hold) begin
				wait_ready();
				@(posedge clk);
				code_in_i <= syms[i];
				encrypt_i <= 1'b1;
			end
			@(posedge clk); // capture edge
			exp_code = expected_code(syms[i]);
			if (hold && i + 1 < count) begin
				code_in_i <= syms[i+1];
			end else begin
				encrypt_i <= 1'b0;
			end
			for (n = 1; n <= TIMEOUT; n++) begin
				@(posedge clk);
				if (!hold) begin
					encrypt_i <= (n < 7) ? 1'($random(seed)) : 1'b0; // ignored while busy
				end
				@(negedge clk);
				if (code_valid_o) begin
					break;
				end
			end
			if (!code_valid_o) begin
				stop_on_error("timeout waiting for code_valid_o");
			end
			assert (n == 7) else
				stop_on_error($sformatf("** Error: code_valid_o latency = %0h, expected %0h",
					n, 7));
			assert (ready_o) else
				stop_on_error($sformatf("** Error: ready_o = %h at code_valid_o, expected %h",
					ready_o, 1'b1));
			assert (code_out_o == exp_code) else
				stop_on_error($sformatf("** Error: code_out_o = %h, expected %h",
					code_out_o, exp_code));
			advance_rotors();
		end
	endtask

	initial begin
		seed       = 33;
		srstn      = 1'b0;
		load_i     = 1'b0;
		encrypt_i  = 1'b0;
		load_idx_i = '0;
		code_in_i  = '0;
		restart_rotors();
		repeat (5) @(posedge clk);
		srstn <= 1'b1;
		@(negedge clk);
		assert (!code_valid_o) else
			stop_on_error($sformatf("** Error: code_valid_o = %h after reset, expected %h",
				code_valid_o, 1'b0));
		assert (!ready_o) else
			stop_on_error($sformatf("** Error: ready_o = %h after reset, expected %h",
				ready_o, 1'b0));
		assert (code_out_o == '0) else
			stop_on_error($sformatf("** Error: code_out_o = %h after reset, expected %h",
				code_out_o, 6'h00));
		load_tables();
		wait_ready();
		restart_rotors(); // offsets restart on entering READY
		run_symbols(120, 1'b0);
		run_symbols(80, 1'b1);
		load_in_ready();
		run_symbols(30, 1'b0);
		run_symbols(30, 1'b1);
		$display("Test passed");
		$finish;
	end

endmodule

//--- list.f
+incdir+dv
logic/enigma_pkg.sv
logic/rotor_if.sv
logic/rotor_bank.sv
logic/enigma_ctrl.sv
logic/enigma_top.sv
dv/enigma_chk.sv
dv/enigma_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module enigma_tb -o enigma_sim

out=$(./obj_dir/enigma_sim || true)
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
	exit 0
fi
exit 1
